// File: verilog/lc3Ctrl_defs.svh
// LC-3 control unit shared widths, opcode values and memory timing
`ifndef LC3CTRL_DEFS_SVH
`define LC3CTRL_DEFS_SVH

`define WORD_WIDTH          16
`define OPCODE_WIDTH        4

// Opcode field values, IR[15:12]
`define OP_BR               4'b0000
`define OP_ADD              4'b0001
`define OP_LD               4'b0010
`define OP_ST               4'b0011
`define OP_JSR              4'b0100    // JSR and JSRR
`define OP_AND              4'b0101
`define OP_LDR              4'b0110
`define OP_STR              4'b0111
`define OP_NOT              4'b1001
`define OP_LDI              4'b1010
`define OP_STI              4'b1011
`define OP_JMP              4'b1100    // Also RET
`define OP_LEA              4'b1110
`define OP_TRAP             4'b1111

// Cycles per memory access, at least 2
`define MEM_ACCESS_CYCLES   3

`endif

// File: verilog/lc3CtrlPkg.sv
// LC-3 control unit types: sequencer states and instruction word views
`include "lc3Ctrl_defs.svh"

package lc3CtrlPkg;

    typedef enum logic [7:0] {
        sHalt,
        sStart,
        sInvalid,
        sFetchAddr,
        sFetchRead,
        sLoadIr,
        sDecode,
        sBrTest,
        sBrTaken,
        sAdd,
        sAnd,
        sNot,
        sLea,
        sLdAddr,
        sLdrAddr,
        sLdiAddr,
        sLdiRead,
        sLdiPtr,
        sLoadRead,
        sLoadReg,
        sStAddr,
        sStrAddr,
        sStiAddr,
        sStiRead,
        sStiPtr,
        sStoreData,
        sStoreWrite,
        sJsrLink,
        sJsrBase,
        sJsrOffset,
        sJmp,
        sTrapVec,
        sTrapLink,
        sTrapRead,
        sTrapJump
    } ctrlState_t;

    // Operate format, as used by ADD, AND and NOT
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]                  opcode;
        logic [2:0]                                dr;
        logic [2:0]                                sr1;
        logic                                      immFlag;   // IR[5]
        logic [`WORD_WIDTH-`OPCODE_WIDTH-8:0]      imm5;
    } operateView_t;

    // JSR format, long PC offset or base register
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]                  opcode;
        logic                                      longFlag;  // IR[11]
        logic [`WORD_WIDTH-`OPCODE_WIDTH-2:0]      offset11;
    } jumpView_t;

    typedef union packed {
        operateView_t op;
        jumpView_t    jump;
    } instrWord_u;

endpackage

// File: verilog/controlSequencer.sv
// Control sequencer: state register and fetch, decode and execute transitions
`timescale 1ns/10ps
`include "lc3Ctrl_defs.svh"

module controlSequencer import lc3CtrlPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       run,
    input  logic       cont,
    input  logic       ben,
    input  instrWord_u ir,
    input  logic       accessLast,
    output ctrlState_t state,
    output logic       accessActive
);

    ctrlState_t nextState;

    always_ff @(posedge Clk) begin
        if (rst)
            state <= sHalt;
        else
            state <= nextState;
    end

    // High for every state that talks to memory
    assign accessActive = (state == sFetchRead) || (state == sLdiRead) ||
                          (state == sStiRead) || (state == sLoadRead) ||
                          (state == sStoreWrite) || (state == sTrapRead);

    always_comb begin
        nextState = state;    // Hold by default
        case (state)
            sHalt:       if (run) nextState = sStart;
            sStart:      if (!run) nextState = sFetchAddr;
            sInvalid:    if (cont) nextState = sHalt;    // Wait for the user

            // Fetch
            sFetchAddr:  nextState = sFetchRead;
            sFetchRead:  if (accessLast) nextState = sLoadIr;
            sLoadIr:     nextState = sDecode;

            sDecode: begin
                case (ir.op.opcode)
                    `OP_BR:   nextState = sBrTest;
                    `OP_ADD:  nextState = sAdd;
                    `OP_LD:   nextState = sLdAddr;
                    `OP_ST:   nextState = sStAddr;
                    `OP_JSR:  nextState = sJsrLink;
                    `OP_AND:  nextState = sAnd;
                    `OP_LDR:  nextState = sLdrAddr;
                    `OP_STR:  nextState = sStrAddr;
                    `OP_NOT:  nextState = sNot;
                    `OP_LDI:  nextState = sLdiAddr;
                    `OP_STI:  nextState = sStiAddr;
                    `OP_JMP:  nextState = sJmp;
                    `OP_LEA:  nextState = sLea;
                    `OP_TRAP: nextState = sTrapVec;
                    default:  nextState = sInvalid;    // 1000 and 1101
                endcase
            end

            // Branch on the BEN register
            sBrTest:     nextState = ben ? sBrTaken : sFetchAddr;
            sBrTaken:    nextState = sFetchAddr;

            // Single-cycle register ops
            sAdd, sAnd, sNot, sLea, sJmp:
                nextState = sFetchAddr;

            // Loads
            sLdAddr, sLdrAddr:
                nextState = sLoadRead;
            sLdiAddr:    nextState = sLdiRead;
            sLdiRead:    if (accessLast) nextState = sLdiPtr;
            sLdiPtr:     nextState = sLoadRead;
            sLoadRead:   if (accessLast) nextState = sLoadReg;
            sLoadReg:    nextState = sFetchAddr;

            // Stores
            sStAddr, sStrAddr:
                nextState = sStoreData;
            sStiAddr:    nextState = sStiRead;
            sStiRead:    if (accessLast) nextState = sStiPtr;
            sStiPtr:     nextState = sStoreData;
            sStoreData:  nextState = sStoreWrite;
            sStoreWrite: if (accessLast) nextState = sFetchAddr;

            // Subroutine call, IR[11] picks PC offset over base register
            sJsrLink:    nextState = ir.jump.longFlag ? sJsrOffset : sJsrBase;
            sJsrBase, sJsrOffset:
                nextState = sFetchAddr;

            // Trap: vector to MAR, link R7, read the vector, jump
            sTrapVec:    nextState = sTrapLink;
            sTrapLink:   nextState = sTrapRead;
            sTrapRead:   if (accessLast) nextState = sTrapJump;
            sTrapJump:   nextState = sFetchAddr;

            default:     nextState = sHalt;    // Unused encodings
        endcase
    end

endmodule

// File: verilog/memAccessTimer.sv
// Memory access timer that flags the final cycle of a fixed-length access
`timescale 1ns/10ps
`include "lc3Ctrl_defs.svh"

module memAccessTimer (
    input  logic Clk,
    input  logic rst,
    input  logic accessActive,
    output logic accessLast
);

    localparam int CountWidth = $clog2(`MEM_ACCESS_CYCLES);

    logic [CountWidth-1:0] count;

    always_ff @(posedge Clk) begin
        if (rst || !accessActive)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    assign accessLast = (count == CountWidth'(`MEM_ACCESS_CYCLES - 1));

endmodule

// File: verilog/controlDecoder.sv
// Control decoder: maps the sequencer state to every datapath control line
`timescale 1ns/10ps

module controlDecoder import lc3CtrlPkg::*; (
    input  ctrlState_t state,
    input  logic       accessLast,
    output logic       ldMar,
    output logic       ldMdr,
    output logic       ldIr,
    output logic       ldBen,
    output logic       ldReg,
    output logic       ldCc,
    output logic       ldPc,
    output logic       gatePc,
    output logic       gateMdr,
    output logic       gateAlu,
    output logic       gateMarMux,
    output logic       addr1Mux,
    output logic [1:0] addr2Mux,
    output logic [1:0] pcMux,
    output logic [1:0] drMux,
    output logic [1:0] sr1Mux,
    output logic       marMux,
    output logic [1:0] aluK,
    output logic       mioEn,
    output logic       rw,
    output logic       halted,
    output logic       paused,
    output logic       invalid
);

    always_comb begin
        ldMar      = 1'b0;
        ldMdr      = 1'b0;
        ldIr       = 1'b0;
        ldBen      = 1'b0;
        ldReg      = 1'b0;
        ldCc       = 1'b0;
        ldPc       = 1'b0;
        gatePc     = 1'b0;
        gateMdr    = 1'b0;
        gateAlu    = 1'b0;
        gateMarMux = 1'b0;
        addr1Mux   = 1'b0;
        addr2Mux   = 2'b00;
        pcMux      = 2'b00;    // PC + 1
        drMux      = 2'b00;
        sr1Mux     = 2'b00;
        marMux     = 1'b0;
        aluK       = 2'b00;
        mioEn      = 1'b0;
        rw         = 1'b0;
        halted     = 1'b0;
        paused     = 1'b0;
        invalid    = 1'b0;

        case (state)
            sFetchAddr: begin    // MAR <- PC, PC <- PC + 1
                gatePc = 1'b1;
                ldMar  = 1'b1;
                ldPc   = 1'b1;
            end
            sFetchRead, sLdiRead, sStiRead, sLoadRead, sTrapRead: begin
                mioEn = 1'b1;
                ldMdr = accessLast;    // Data valid on the last cycle
            end
            sLoadIr: begin
                gateMdr = 1'b1;
                ldIr    = 1'b1;
                paused  = 1'b1;
            end
            sDecode:     ldBen = 1'b1;
            sBrTaken: begin      // PC <- PC + off9
                addr2Mux = 2'b10;
                pcMux    = 2'b10;
                ldPc     = 1'b1;
            end
            sAdd, sAnd, sNot: begin
                sr1Mux  = 2'b01;
                gateAlu = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
                if (state == sAnd)
                    aluK = 2'b01;
                else if (state == sNot)
                    aluK = 2'b10;
            end
            sLdAddr, sStAddr, sLdiAddr, sStiAddr: begin    // MAR <- PC + off9
                addr2Mux   = 2'b10;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            sLdrAddr, sStrAddr: begin    // MAR <- BaseR + off6
                sr1Mux     = 2'b01;
                addr1Mux   = 1'b1;
                addr2Mux   = 2'b01;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            sLdiPtr, sStiPtr: begin    // MAR <- MDR
                gateMdr = 1'b1;
                ldMar   = 1'b1;
            end
            sLoadReg: begin
                gateMdr = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
            end
            sStoreData: begin    // MDR <- SR through ALU pass
                aluK    = 2'b11;
                gateAlu = 1'b1;
                ldMdr   = 1'b1;
            end
            sStoreWrite: begin
                // Write strobe drops on the final cycle
                mioEn = !accessLast;
                rw    = !accessLast;
            end
            sJsrLink, sTrapLink: begin    // R7 <- PC
                drMux  = 2'b01;
                gatePc = 1'b1;
                ldReg  = 1'b1;
            end
            sJsrBase, sJmp: begin    // PC <- BaseR
                sr1Mux   = 2'b01;
                addr1Mux = 1'b1;
                pcMux    = 2'b10;
                ldPc     = 1'b1;
            end
            sJsrOffset: begin    // PC <- PC + off11
                addr2Mux = 2'b11;
                pcMux    = 2'b10;
                ldPc     = 1'b1;
            end
            sLea: begin
                addr2Mux   = 2'b10;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldReg      = 1'b1;
                ldCc       = 1'b1;
            end
            sTrapVec: begin      // MAR <- ZEXT(trapvect8)
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            sTrapJump: begin
                gateMdr = 1'b1;
                pcMux   = 2'b01;
                ldPc    = 1'b1;
            end
            sInvalid:    invalid = 1'b1;
            sHalt:       halted = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: verilog/lc3Control.sv
// LC-3 control unit top: sequencer, memory access timer and control decoder
`timescale 1ns/10ps

module lc3Control import lc3CtrlPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       run,
    input  logic       cont,
    input  logic       ben,
    input  instrWord_u ir,
    output logic       ldMar,
    output logic       ldMdr,
    output logic       ldIr,
    output logic       ldBen,
    output logic       ldReg,
    output logic       ldCc,
    output logic       ldPc,
    output logic       gatePc,
    output logic       gateMdr,
    output logic       gateAlu,
    output logic       gateMarMux,
    output logic       addr1Mux,
    output logic [1:0] addr2Mux,
    output logic [1:0] pcMux,
    output logic [1:0] drMux,
    output logic [1:0] sr1Mux,
    output logic       marMux,
    output logic [1:0] aluK,
    output logic       mioEn,
    output logic       rw,
    output logic       halted,
    output logic       paused,
    output logic       invalid
);

    ctrlState_t state;
    logic       accessActive;
    logic       accessLast;

    controlSequencer u_controlSequencer (
        .Clk          (Clk),
        .rst          (rst),
        .run          (run),
        .cont         (cont),
        .ben          (ben),
        .ir           (ir),
        .accessLast   (accessLast),
        .state        (state),
        .accessActive (accessActive)
    );

    memAccessTimer u_memAccessTimer (
        .Clk          (Clk),
        .rst          (rst),
        .accessActive (accessActive),
        .accessLast   (accessLast)
    );

    controlDecoder u_controlDecoder (
        .state      (state),
        .accessLast (accessLast),
        .ldMar      (ldMar),
        .ldMdr      (ldMdr),
        .ldIr       (ldIr),
        .ldBen      (ldBen),
        .ldReg      (ldReg),
        .ldCc       (ldCc),
        .ldPc       (ldPc),
        .gatePc     (gatePc),
        .gateMdr    (gateMdr),
        .gateAlu    (gateAlu),
        .gateMarMux (gateMarMux),
        .addr1Mux   (addr1Mux),
        .addr2Mux   (addr2Mux),
        .pcMux      (pcMux),
        .drMux      (drMux),
        .sr1Mux     (sr1Mux),
        .marMux     (marMux),
        .aluK       (aluK),
        .mioEn      (mioEn),
        .rw         (rw),
        .halted     (halted),
        .paused     (paused),
        .invalid    (invalid)
    );

endmodule

// File: testbench/lc3ControlModel.svh
// LC-3 control reference model: next-state table, access counter and control table
`ifndef LC3CONTROL_MODEL_SVH
`define LC3CONTROL_MODEL_SVH

// Bit positions in the packed output vector, ldMar first and invalid last
localparam logic [27:0] ldMarBit      = 28'd1 << 27;
localparam logic [27:0] ldMdrBit      = 28'd1 << 26;
localparam logic [27:0] ldIrBit       = 28'd1 << 25;
localparam logic [27:0] ldBenBit      = 28'd1 << 24;
localparam logic [27:0] ldRegBit      = 28'd1 << 23;
localparam logic [27:0] ldCcBit       = 28'd1 << 22;
localparam logic [27:0] ldPcBit       = 28'd1 << 21;
localparam logic [27:0] gatePcBit     = 28'd1 << 20;
localparam logic [27:0] gateMdrBit    = 28'd1 << 19;
localparam logic [27:0] gateAluBit    = 28'd1 << 18;
localparam logic [27:0] gateMarMuxBit = 28'd1 << 17;
localparam logic [27:0] addr1BaseBit  = 28'd1 << 16;
localparam logic [27:0] addr2Off6     = 28'd1 << 14;
localparam logic [27:0] addr2Off9     = 28'd2 << 14;
localparam logic [27:0] addr2Off11    = 28'd3 << 14;
localparam logic [27:0] pcFromBus     = 28'd1 << 12;
localparam logic [27:0] pcFromAdder   = 28'd2 << 12;
localparam logic [27:0] drR7          = 28'd1 << 10;
localparam logic [27:0] sr1Base       = 28'd1 << 8;
localparam logic [27:0] marMuxBit     = 28'd1 << 7;
localparam logic [27:0] aluAnd        = 28'd1 << 5;
localparam logic [27:0] aluNot        = 28'd2 << 5;
localparam logic [27:0] aluPass       = 28'd3 << 5;
localparam logic [27:0] mioEnBit      = 28'd1 << 4;
localparam logic [27:0] rwBit         = 28'd1 << 3;
localparam logic [27:0] haltedBit     = 28'd1 << 2;
localparam logic [27:0] pausedBit     = 28'd1 << 1;
localparam logic [27:0] invalidBit    = 28'd1;
localparam logic [27:0] aluToReg      = sr1Base | gateAluBit | ldRegBit | ldCcBit;

ctrlState_t modelState;
int         modelCount;    // Cycles spent in the current access

function automatic logic modelAccess(ctrlState_t s);
    return s inside {sFetchRead, sLdiRead, sStiRead, sLoadRead, sStoreWrite, sTrapRead};
endfunction

// One clock edge of the sequencer and the access counter
task automatic modelStep(input logic rstIn, input logic runIn, input logic contIn,
                         input logic benIn, input logic [`WORD_WIDTH-1:0] irIn);
    ctrlState_t nxt;
    logic       last;
    last = (modelCount == `MEM_ACCESS_CYCLES - 1);
    nxt = modelState;
    case (modelState)
        sHalt:       if (runIn) nxt = sStart;
        sStart:      if (!runIn) nxt = sFetchAddr;
        sInvalid:    if (contIn) nxt = sHalt;
        sFetchAddr:  nxt = sFetchRead;
        sFetchRead:  if (last) nxt = sLoadIr;
        sLoadIr:     nxt = sDecode;
        sDecode: begin
            case (irIn[`WORD_WIDTH-1 -: `OPCODE_WIDTH])
                `OP_BR:   nxt = sBrTest;
                `OP_ADD:  nxt = sAdd;
                `OP_LD:   nxt = sLdAddr;
                `OP_ST:   nxt = sStAddr;
                `OP_JSR:  nxt = sJsrLink;
                `OP_AND:  nxt = sAnd;
                `OP_LDR:  nxt = sLdrAddr;
                `OP_STR:  nxt = sStrAddr;
                `OP_NOT:  nxt = sNot;
                `OP_LDI:  nxt = sLdiAddr;
                `OP_STI:  nxt = sStiAddr;
                `OP_JMP:  nxt = sJmp;
                `OP_LEA:  nxt = sLea;
                `OP_TRAP: nxt = sTrapVec;
                default:  nxt = sInvalid;
            endcase
        end
        sBrTest:     nxt = benIn ? sBrTaken : sFetchAddr;
        sLdAddr, sLdrAddr:
            nxt = sLoadRead;
        sLdiAddr:    nxt = sLdiRead;
        sLdiRead:    if (last) nxt = sLdiPtr;
        sLdiPtr:     nxt = sLoadRead;
        sLoadRead:   if (last) nxt = sLoadReg;
        sStAddr, sStrAddr:
            nxt = sStoreData;
        sStiAddr:    nxt = sStiRead;
        sStiRead:    if (last) nxt = sStiPtr;
        sStiPtr:     nxt = sStoreData;
        sStoreData:  nxt = sStoreWrite;
        sStoreWrite: if (last) nxt = sFetchAddr;
        sJsrLink:    nxt = irIn[11] ? sJsrOffset : sJsrBase;    // Long offset flag
        sTrapVec:    nxt = sTrapLink;
        sTrapLink:   nxt = sTrapRead;
        sTrapRead:   if (last) nxt = sTrapJump;
        default:     nxt = sFetchAddr;    // Final execute cycle of the rest
    endcase
    if (rstIn) begin
        modelState = sHalt;
        modelCount = 0;
    end else begin
        modelCount = (modelAccess(modelState) && !last) ? modelCount + 1 : 0;
        modelState = nxt;
    end
endtask

// Expected control outputs for the current model state
function automatic logic [27:0] modelOutputs();
    logic last;
    last = (modelCount == `MEM_ACCESS_CYCLES - 1);
    case (modelState)
        sFetchAddr:  return gatePcBit | ldMarBit | ldPcBit;
        sFetchRead, sLdiRead, sStiRead, sLoadRead, sTrapRead:
            return last ? (mioEnBit | ldMdrBit) : mioEnBit;
        sLoadIr:     return gateMdrBit | ldIrBit | pausedBit;
        sDecode:     return ldBenBit;
        sBrTaken:    return addr2Off9 | pcFromAdder | ldPcBit;
        sAdd:        return aluToReg;
        sAnd:        return aluToReg | aluAnd;
        sNot:        return aluToReg | aluNot;
        sLdAddr, sStAddr, sLdiAddr, sStiAddr:
            return addr2Off9 | marMuxBit | gateMarMuxBit | ldMarBit;
        sLdrAddr, sStrAddr:
            return sr1Base | addr1BaseBit | addr2Off6 | marMuxBit | gateMarMuxBit | ldMarBit;
        sLdiPtr, sStiPtr:
            return gateMdrBit | ldMarBit;
        sLoadReg:    return gateMdrBit | ldRegBit | ldCcBit;
        sStoreData:  return aluPass | gateAluBit | ldMdrBit;
        sStoreWrite: return last ? 28'd0 : (mioEnBit | rwBit);
        sJsrLink, sTrapLink:
            return drR7 | gatePcBit | ldRegBit;
        sJsrBase, sJmp:
            return sr1Base | addr1BaseBit | pcFromAdder | ldPcBit;
        sJsrOffset:  return addr2Off11 | pcFromAdder | ldPcBit;
        sLea:        return addr2Off9 | marMuxBit | gateMarMuxBit | ldRegBit | ldCcBit;
        sTrapVec:    return gateMarMuxBit | ldMarBit;
        sTrapJump:   return gateMdrBit | pcFromBus | ldPcBit;
        sInvalid:    return invalidBit;
        sHalt:       return haltedBit;
        default:     return 28'd0;
    endcase
endfunction

`endif

// File: testbench/tbLc3Control.sv
// LC-3 control unit testbench with a random instruction stream checked against a cycle model
`timescale 1ns/10ps
`include "lc3Ctrl_defs.svh"

module tbLc3Control import lc3CtrlPkg::*; ();

    localparam int NumInstr = 400;

    logic       Clk;
    logic       rst;
    logic       run;
    logic       cont;
    logic       ben;
    instrWord_u ir;
    logic       ldMar, ldMdr, ldIr, ldBen, ldReg, ldCc, ldPc;
    logic       gatePc, gateMdr, gateAlu, gateMarMux, addr1Mux, marMux;
    logic [1:0] addr2Mux, pcMux, drMux, sr1Mux, aluK;
    logic       mioEn, rw, halted, paused, invalid;
    logic [27:0] dutOut;

    int errors;
    int cycles;
    bit autoRun;    // Restart from halt on its own

    `include "lc3ControlModel.svh"

    lc3Control u_lc3Control (.*);

    assign dutOut = {ldMar, ldMdr, ldIr, ldBen, ldReg, ldCc, ldPc, gatePc, gateMdr, gateAlu,
                     gateMarMux, addr1Mux, addr2Mux, pcMux, drMux, sr1Mux, marMux, aluK,
                     mioEn, rw, halted, paused, invalid};

    always #10 Clk = ~Clk;

    function automatic string behaviorName(ctrlState_t s);
        case (s)
            sHalt:    return autoRun ? "run sequence" : "reset";
            sStart:   return "run sequence";
            sInvalid: return "invalid opcode";
            sFetchAddr, sFetchRead, sLoadIr, sDecode:
                return "fetch and decode";
            sBrTest, sBrTaken, sAdd, sAnd, sNot, sLea, sJmp, sJsrLink, sJsrBase, sJsrOffset:
                return "register and control flow";
            default:  return "memory instructions";
        endcase
    endfunction

    // Uniform opcode so both invalid values come up as well
    function automatic logic [`WORD_WIDTH-1:0] randomInstr();
        logic [`WORD_WIDTH-1:0] word;
        word = `WORD_WIDTH'($urandom);
        word[`WORD_WIDTH-1 -: `OPCODE_WIDTH] = `OPCODE_WIDTH'($urandom % 16);
        return word;
    endfunction

    task automatic checkOutputs();
        logic [27:0] expOut;
        expOut = modelOutputs();
        assert (dutOut === expOut)
        else begin
            errors++;
            $display("MISMATCH %s (%s): expected %h actual %h",
                     behaviorName(modelState), modelState.name(), expOut, dutOut);
        end
    endtask

    // Step the model on the sampled inputs, drive new ones and check at negedge
    task automatic runCycle(input logic keepReset);
        @(posedge Clk);
        modelStep(rst, run, cont, ben, ir);
        rst  <= keepReset;
        ben  <= ($urandom % 2) == 1;
        cont <= ($urandom % 8) == 0;
        run  <= autoRun && (modelState == sHalt);
        if (modelState == sFetchAddr)
            ir <= randomInstr();
        cycles++;
        @(negedge Clk);
        checkOutputs();
    endtask

    task automatic waitForState(input ctrlState_t target, input int limit, input string what);
        int n;
        n = 0;
        while (modelState != target && n < limit) begin
            runCycle(1'b0);
            n++;
        end
        assert (modelState == target)
        else begin
            errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    initial begin
        void'($urandom(32'h03aeb6f5));
        Clk = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        cont = 1'b0;
        ben = 1'b0;
        ir = '0;
        autoRun = 1'b0;
        errors = 0;
        cycles = 0;
        modelState = sHalt;
        modelCount = 0;

        repeat (3) runCycle(1'b1);
        runCycle(1'b0);          // Fourth reset cycle before release
        repeat (6) runCycle(1'b0);    // Stays halted with run low

        autoRun = 1'b1;
        waitForState(sFetchAddr, 10, "the first fetch after run");
        for (int i = 0; i < NumInstr; i++) begin
            runCycle(1'b0);
            waitForState(sFetchAddr, 300, "the next instruction fetch");
        end

        $display("Checked %0d cycles, %0d errors", cycles, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
+incdir+testbench
verilog/lc3CtrlPkg.sv
verilog/controlSequencer.sv
verilog/memAccessTimer.sv
verilog/controlDecoder.sv
verilog/lc3Control.sv
testbench/tbLc3Control.sv
